// File: lsq_settings.svh
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// queue entries, kept a power of two
`define LSQ_DEPTH 8

// reorder-buffer tag, zero means value present
`define TAG_WIDTH 4

`define DATA_WIDTH 32

// word-addressed data memory
`define MEM_WORDS 64

`endif

// File: lsqPkg.sv
`include "lsq_settings.svh"

package lsqPkg;

    // bit 2 set marks a store
    typedef enum logic [2:0] {
        loadWord  = 3'b000,
        loadHalf  = 3'b001,
        loadByte  = 3'b010,
        storeWord = 3'b100,
        storeHalf = 3'b101,
        storeByte = 3'b110
    } lsqOp_e;

    typedef enum logic [1:0] {
        idle,
        waitAck,
        waitDrop
    } memState_e;

    typedef struct packed {
        lsqOp_e                  op;
        logic [`DATA_WIDTH-1:0]  baseVal;
        logic [`TAG_WIDTH-1:0]   baseTag;
        logic [`DATA_WIDTH-1:0]  dataVal;
        logic [`TAG_WIDTH-1:0]   dataTag;
        logic [`DATA_WIDTH-1:0]  offset;
        logic [`TAG_WIDTH-1:0]   destTag;
    } issueEntry_t;

    typedef struct packed {
        logic                    valid;
        logic [`TAG_WIDTH-1:0]   tag;
        logic [`DATA_WIDTH-1:0]  data;
    } cdbMsg_t;

    typedef struct packed {
        logic                    write;
        logic [`DATA_WIDTH-1:0]  addr;
        logic [`DATA_WIDTH-1:0]  data;
    } memReq_t;

    function automatic logic isStore(lsqOp_e op);
        return op[2];
    endfunction

    // capture broadcast values for any source still waiting on a tag
    function automatic issueEntry_t wakeEntry(issueEntry_t entry, cdbMsg_t busA, cdbMsg_t busB);
        cdbMsg_t buses [2];
        issueEntry_t woken;
        buses[0] = busA;
        buses[1] = busB;
        woken = entry;
        foreach (buses[b]) begin
            if (buses[b].valid && buses[b].tag != '0) begin
                if (woken.baseTag == buses[b].tag) begin
                    woken.baseVal = buses[b].data;
                    woken.baseTag = '0;
                end
                if (woken.dataTag == buses[b].tag) begin
                    woken.dataVal = buses[b].data;
                    woken.dataTag = '0;
                end
            end
        end
        return woken;
    endfunction

endpackage

// File: issueStage.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module issueStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rollback,
    input  logic                 dispatchReq,
    input  lsqPkg::issueEntry_t  dispatchEntry,
    input  lsqPkg::cdbMsg_t      aluCdb,
    input  lsqPkg::cdbMsg_t      loadCdb,
    input  logic                 queueFull,
    output logic                 dispatchAck,
    output logic                 allocValid,
    output lsqPkg::issueEntry_t  allocEntry
);
    import lsqPkg::*;

    issueEntry_t heldEntry;
    logic        pending;
    logic        allocPulse;
    logic        acceptReq;

    assign acceptReq = dispatchReq && !dispatchAck && !queueFull && !rollback;

    // entry goes to the queue in the first ack cycle
    assign allocValid = allocPulse && !rollback;
    assign allocEntry = wakeEntry(heldEntry, aluCdb, loadCdb);

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatchAck <= 1'b0;
            allocPulse  <= 1'b0;
            pending     <= 1'b0;
        end else begin
            allocPulse <= acceptReq;
            pending    <= dispatchReq && !dispatchAck;
            if (acceptReq) begin
                dispatchAck <= 1'b1;
            end else if (!dispatchReq) begin
                dispatchAck <= 1'b0;
            end
        end
    end

    // a request held while full keeps collecting wakeups
    always_ff @(posedge clk) begin
        if (dispatchReq && !dispatchAck) begin
            heldEntry <= wakeEntry(pending ? heldEntry : dispatchEntry, aluCdb, loadCdb);
        end
    end

    ackNeedsRoom: assert property (
        @(posedge clk) disable iff (rst)
        $rose(dispatchAck) |-> !queueFull
    ) else $error("dispatchAck raised while the queue was full");

endmodule

// File: loadStoreQueue.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module loadStoreQueue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rollback,
    input  logic                    allocValid,
    input  lsqPkg::issueEntry_t     allocEntry,
    input  lsqPkg::cdbMsg_t         aluCdb,
    input  logic [`TAG_WIDTH-1:0]   commitTag,
    input  logic                    memAck,
    input  logic [`DATA_WIDTH-1:0]  memRdData,
    output logic                    queueFull,
    output logic                    memReqValid,
    output lsqPkg::memReq_t         memReq,
    output lsqPkg::cdbMsg_t         loadResult
);
    import lsqPkg::*;

    // pointers wrap on their own since the depth is a power of two
    localparam int PtrWidth   = $clog2(`LSQ_DEPTH);
    localparam int CountWidth = $clog2(`LSQ_DEPTH + 1);

    issueEntry_t             entries [`LSQ_DEPTH];
    issueEntry_t             woken [`LSQ_DEPTH];
    logic [`DATA_WIDTH-1:0]  effAddr [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0]   busy;
    logic [`LSQ_DEPTH-1:0]   committed;
    logic [PtrWidth-1:0]     head;
    logic [PtrWidth-1:0]     tail;
    logic [CountWidth-1:0]   count;
    logic [CountWidth-1:0]   keepCount;
    memState_e               state;
    issueEntry_t             headEntry;
    logic                    headStore;
    logic                    headReady;
    logic                    startReq;
    logic                    abortReq;
    logic                    finishReq;
    logic                    resultValid;
    logic [`TAG_WIDTH-1:0]   resultTag;
    logic [`DATA_WIDTH-1:0]  resultData;

    assign queueFull  = (count == CountWidth'(`LSQ_DEPTH));
    assign loadResult = '{valid: resultValid, tag: resultTag, data: resultData};

    assign headEntry = entries[head];
    assign headStore = isStore(headEntry.op);

    // stores also wait for their data and the commit
    assign headReady = busy[head] && headEntry.baseTag == '0 &&
                       (!headStore || (headEntry.dataTag == '0 && committed[head]));

    assign startReq  = state == idle && headReady && !memAck && !rollback;
    assign abortReq  = state == waitAck && rollback && !committed[head];
    assign finishReq = state == waitAck && memAck && !abortReq;

    always_comb begin
        keepCount = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            woken[i]  = wakeEntry(entries[i], aluCdb, loadResult);
            // committed entries form a prefix from the head
            keepCount = keepCount + CountWidth'(busy[i] && committed[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            entries[i] <= woken[i];
            if (woken[i].baseTag == '0) begin
                effAddr[i] <= woken[i].baseVal + woken[i].offset;
            end
        end
        if (allocValid && !rollback) begin
            entries[tail] <= allocEntry;
            effAddr[tail] <= allocEntry.baseVal + allocEntry.offset;
        end
        if (startReq) begin
            memReq.write <= headStore;
            memReq.addr  <= effAddr[head];
            memReq.data  <= headEntry.dataVal;
        end
        if (finishReq) begin
            resultTag  <= headEntry.destTag;
            resultData <= memRdData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            busy        <= '0;
            committed   <= '0;
            state       <= idle;
            memReqValid <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;

            // head sequencer
            case (state)
                idle: begin
                    if (startReq) begin
                        memReqValid <= 1'b1;
                        state       <= waitAck;
                    end
                end
                waitAck: begin
                    if (abortReq || finishReq) begin
                        memReqValid <= 1'b0;
                        resultValid <= finishReq && !headStore;
                        state       <= waitDrop;
                    end
                end
                default: begin
                    if (!memAck) begin
                        state <= idle;
                    end
                end
            endcase

            if (rollback) begin
                busy      <= busy & committed;
                committed <= busy & committed;
                if (finishReq) begin
                    busy[head]      <= 1'b0;
                    committed[head] <= 1'b0;
                    head            <= head + 1'b1;
                end
                tail  <= head + keepCount[PtrWidth-1:0];
                count <= keepCount - CountWidth'(finishReq);
            end else begin
                if (commitTag != '0) begin
                    for (int i = 0; i < `LSQ_DEPTH; i++) begin
                        if (busy[i] && isStore(entries[i].op) && entries[i].destTag == commitTag) begin
                            committed[i] <= 1'b1;
                        end
                    end
                end
                if (allocValid) begin
                    busy[tail]      <= 1'b1;
                    committed[tail] <= 1'b0;
                    tail            <= tail + 1'b1;
                end
                if (finishReq) begin
                    busy[head]      <= 1'b0;
                    committed[head] <= 1'b0;
                    head            <= head + 1'b1;
                end
                count <= count + CountWidth'(allocValid) - CountWidth'(finishReq);
            end
        end
    end

    countBound: assert property (
        @(posedge clk) disable iff (rst)
        count <= CountWidth'(`LSQ_DEPTH)
    ) else $error("queue count above depth");

    storeOnlyCommitted: assert property (
        @(posedge clk) disable iff (rst)
        $rose(memReqValid) && memReq.write |-> committed[head]
    ) else $error("memory write issued for an uncommitted store");

endmodule

// File: memoryPort.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module memoryPort (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    memReqValid,
    input  lsqPkg::memReq_t         memReq,
    output logic                    memAck,
    output logic [`DATA_WIDTH-1:0]  memRdData
);
    import lsqPkg::*;

    localparam int AddrWidth = $clog2(`MEM_WORDS);

    logic [`DATA_WIDTH-1:0]  mem [`MEM_WORDS];
    logic [AddrWidth-1:0]    wordIndex;
    memState_e               state;

    // address wraps modulo the memory depth
    assign wordIndex = memReq.addr[AddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            memRdData <= '0;
            memAck    <= 1'b0;
            state     <= idle;
        end else begin
            case (state)
                idle: begin
                    // one access per request, then hold ack
                    if (memReqValid) begin
                        if (memReq.write) begin
                            mem[wordIndex] <= memReq.data;
                        end else begin
                            memRdData <= mem[wordIndex];
                        end
                        memAck <= 1'b1;
                        state  <= waitDrop;
                    end
                end
                default: begin
                    if (!memReqValid) begin
                        memAck <= 1'b0;
                        state  <= idle;
                    end
                end
            endcase
        end
    end

    ackFallsAfterReq: assert property (
        @(posedge clk) disable iff (rst)
        $fell(memAck) |-> $past(!memReqValid)
    ) else $error("memAck dropped while the request was still high");

endmodule

// File: lsqTop.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module lsqTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatchReq,
    output logic                   dispatchAck,
    input  lsqPkg::issueEntry_t    dispatchEntry,
    input  lsqPkg::cdbMsg_t        aluCdb,
    input  logic [`TAG_WIDTH-1:0]  commitTag,
    input  logic                   rollback,
    output lsqPkg::cdbMsg_t        loadResult,
    output logic                   lsqFull
);
    import lsqPkg::*;

    logic                    allocValid;
    issueEntry_t             allocEntry;
    logic                    memReqValid;
    memReq_t                 memReq;
    logic                    memAck;
    logic [`DATA_WIDTH-1:0]  memRdData;

    // load results loop back for same-cycle wakeup at dispatch
    issueStage issue0 (
        .clk           (clk),
        .rst           (rst),
        .rollback      (rollback),
        .dispatchReq   (dispatchReq),
        .dispatchEntry (dispatchEntry),
        .aluCdb        (aluCdb),
        .loadCdb       (loadResult),
        .queueFull     (lsqFull),
        .dispatchAck   (dispatchAck),
        .allocValid    (allocValid),
        .allocEntry    (allocEntry)
    );

    loadStoreQueue queue0 (
        .clk         (clk),
        .rst         (rst),
        .rollback    (rollback),
        .allocValid  (allocValid),
        .allocEntry  (allocEntry),
        .aluCdb      (aluCdb),
        .commitTag   (commitTag),
        .memAck      (memAck),
        .memRdData   (memRdData),
        .queueFull   (lsqFull),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .loadResult  (loadResult)
    );

    memoryPort mem0 (
        .clk         (clk),
        .rst         (rst),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memAck      (memAck),
        .memRdData   (memRdData)
    );

endmodule

// File: lsqClock.sv
`timescale 1ns/1ps

module lsqClock #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: lsqTb.sv
`timescale 1ns/1ps
`include "lsq_settings.svh"

module lsqTb;
    import lsqPkg::*;

    localparam int NumFill     = 8;
    localparam int NumReady    = 10;
    localparam int TotalOps    = 2 * NumFill + NumReady + 20;
    localparam int CyclesPerOp = 40;
    localparam int PeriodNs    = 40;
    localparam int AddrBits    = $clog2(`MEM_WORDS);
    // source tags above the destination tag range
    localparam logic [`TAG_WIDTH-1:0] WakeTagA = 13;
    localparam logic [`TAG_WIDTH-1:0] WakeTagB = 14;
    localparam logic [`TAG_WIDTH-1:0] DataTag  = 15;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]   tag;
        logic [`DATA_WIDTH-1:0]  data;
    } expResult_t;

    logic clk, rst, dispatchReq, dispatchAck, rollback, lsqFull;
    issueEntry_t dispatchEntry;
    cdbMsg_t aluCdb, loadResult;
    logic [`TAG_WIDTH-1:0] commitTag, tagCounter;
    logic [`DATA_WIDTH-1:0] shadow [`MEM_WORDS];
    logic [`DATA_WIDTH-1:0] fillAddr [NumFill];
    logic [`DATA_WIDTH-1:0] fullAddr [`LSQ_DEPTH];
    logic [`TAG_WIDTH-1:0] storeTags [`LSQ_DEPTH];
    expResult_t expQ [$];
    expResult_t expFront;
    logic expValid, resultBlocked, expectFull;
    logic [31:0] lfsrState;
    int errorCount, resultsSeen;

    lsqClock #(.PeriodNs(PeriodNs), .ResetCycles(2)) clock0 (.clk(clk), .rst(rst));

    lsqTop dut0 (
        .clk(clk), .rst(rst), .dispatchReq(dispatchReq), .dispatchAck(dispatchAck),
        .dispatchEntry(dispatchEntry), .aluCdb(aluCdb), .commitTag(commitTag),
        .rollback(rollback), .loadResult(loadResult), .lsqFull(lsqFull)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return val;
    endfunction

    function automatic logic [`TAG_WIDTH-1:0] nextTag();
        tagCounter = (tagCounter == 4'd12) ? 4'd1 : tagCounter + 1'b1;
        return tagCounter;
    endfunction

    function automatic issueEntry_t makeEntry(lsqOp_e op, logic [31:0] baseVal,
            logic [3:0] baseTag, logic [31:0] dataVal, logic [3:0] dataTag,
            logic [31:0] offset, logic [3:0] destTag);
        return '{op: op, baseVal: baseVal, baseTag: baseTag, dataVal: dataVal,
                 dataTag: dataTag, offset: offset, destTag: destTag};
    endfunction

    function automatic void refreshFront();
        expValid = expQ.size() > 0;
        expFront = '0;
        if (expValid) begin
            expFront = expQ[0];
        end
    endfunction

    function automatic void pushExpected(logic [3:0] tag, logic [31:0] addr);
        expQ.push_back('{tag: tag, data: shadow[addr[AddrBits-1:0]]});
        refreshFront();
    endfunction

    task automatic dispatchOne(input issueEntry_t entry, input cdbMsg_t bcast);
        @(posedge clk);
        dispatchEntry <= entry;
        dispatchReq   <= 1'b1;
        aluCdb        <= bcast;
        @(posedge clk);
        aluCdb <= '0;
        while (!dispatchAck) begin
            @(posedge clk);
        end
        dispatchReq <= 1'b0;
        while (dispatchAck) begin
            @(posedge clk);
        end
    endtask

    task automatic broadcastAlu(input logic [3:0] tag, input logic [31:0] data);
        @(posedge clk);
        aluCdb <= '{valid: 1'b1, tag: tag, data: data};
        @(posedge clk);
        aluCdb <= '0;
    endtask

    task automatic commitStore(input logic [3:0] tag);
        @(posedge clk);
        commitTag <= tag;
        @(posedge clk);
        commitTag <= '0;
    endtask

    task automatic pulseRollback();
        @(posedge clk);
        rollback <= 1'b1;
        @(posedge clk);
        rollback <= 1'b0;
    endtask

    task automatic waitDrained();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && loadResult.valid) begin
            resultsSeen++;
            if (expQ.size() > 0) begin
                void'(expQ.pop_front());
            end
            refreshFront();
        end
    end

    resultMatches: assert property (@(posedge clk) disable iff (rst)
        loadResult.valid |-> expValid && loadResult.tag == expFront.tag &&
                             loadResult.data == expFront.data
    ) else begin
        errorCount++;
        $display("[ERROR] %0t load result tag %0d data %h, expected tag %0d data %h",
                 $time, $sampled(loadResult.tag), $sampled(loadResult.data),
                 $sampled(expFront.tag), $sampled(expFront.data));
    end

    noEarlyResult: assert property (@(posedge clk) disable iff (rst)
        loadResult.valid |-> !resultBlocked
    ) else begin
        errorCount++;
        $display("[ERROR] %0t load result before its wakeup or store commit", $time);
    end

    fullHoldsDispatch: assert property (@(posedge clk) disable iff (rst)
        expectFull |-> lsqFull && !dispatchAck
    ) else begin
        errorCount++;
        $display("[ERROR] %0t full queue: lsqFull %0b dispatchAck %0b", $time,
                 $sampled(lsqFull), $sampled(dispatchAck));
    end

    resetClears: assert property (@(posedge clk)
        $fell(rst) |-> !dispatchAck && !loadResult.valid && !lsqFull
    ) else begin
        errorCount++;
        $display("[ERROR] %0t outputs not cleared by reset", $time);
    end

    initial begin
        #(TotalOps * CyclesPerOp * PeriodNs);
        $display("timeout, the run did not finish within %0d cycles", TotalOps * CyclesPerOp);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [`DATA_WIDTH-1:0] base, addr, data, wakeVal;
        logic [`TAG_WIDTH-1:0] tag, sTag;
        dispatchReq = 1'b0;
        dispatchEntry = '0;
        aluCdb = '0;
        commitTag = '0;
        rollback = 1'b0;
        expectFull = 1'b0;
        resultBlocked = 1'b0;
        errorCount = 0;
        resultsSeen = 0;
        lfsrState = 32'd35;
        tagCounter = '0;
        refreshFront();
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        wait (rst === 1'b0);

        // committed stores give the loads something to read
        for (int i = 0; i < NumFill; i++) begin
            base = takeBits(32);
            fillAddr[i] = takeBits(32);
            data = takeBits(32);
            tag = nextTag();
            shadow[fillAddr[i][AddrBits-1:0]] = data;
            dispatchOne(makeEntry(storeWord, base, '0, data, '0, fillAddr[i] - base, tag), '0);
            commitStore(tag);
        end
        for (int i = 0; i < NumReady; i++) begin
            base = takeBits(32);
            addr = i[0] ? takeBits(32) : fillAddr[takeBits(3)];
            tag = nextTag();
            pushExpected(tag, addr);
            dispatchOne(makeEntry(loadWord, base, '0, '0, '0, addr - base, tag), '0);
        end

        // base arrives later on the ALU bus
        waitDrained();
        wakeVal = takeBits(32);
        addr = fillAddr[takeBits(3)];
        tag = nextTag();
        pushExpected(tag, addr);
        resultBlocked = 1'b1;
        dispatchOne(makeEntry(loadWord, takeBits(32), WakeTagA, '0, '0, addr - wakeVal, tag), '0);
        repeat (6) @(posedge clk);
        broadcastAlu(WakeTagA, wakeVal);
        resultBlocked = 1'b0;
        wakeVal = takeBits(32);
        addr = fillAddr[takeBits(3)];
        tag = nextTag();
        pushExpected(tag, addr);
        dispatchOne(makeEntry(loadWord, takeBits(32), WakeTagB, '0, '0, addr - wakeVal, tag),
                    '{valid: 1'b1, tag: WakeTagB, data: wakeVal});

        // load behind a store waits for the commit
        waitDrained();
        addr = takeBits(32);
        data = takeBits(32);
        base = takeBits(32);
        sTag = nextTag();
        shadow[addr[AddrBits-1:0]] = data;
        resultBlocked = 1'b1;
        dispatchOne(makeEntry(storeWord, base, '0, data, '0, addr - base, sTag), '0);
        base = takeBits(32);
        tag = nextTag();
        pushExpected(tag, addr);
        dispatchOne(makeEntry(loadWord, base, '0, '0, '0, addr - base, tag), '0);
        repeat (6) @(posedge clk);
        commitStore(sTag);
        resultBlocked = 1'b0;

        // committed store with late data survives, younger loads are squashed
        waitDrained();
        addr = takeBits(32);
        data = takeBits(32);
        base = takeBits(32);
        sTag = nextTag();
        shadow[addr[AddrBits-1:0]] = data;
        dispatchOne(makeEntry(storeWord, base, '0, takeBits(32), DataTag, addr - base, sTag), '0);
        commitStore(sTag);
        for (int i = 0; i < 2; i++) begin
            dispatchOne(makeEntry(loadWord, takeBits(32), '0, '0, '0, takeBits(32), nextTag()), '0);
        end
        repeat (4) @(posedge clk);
        pulseRollback();
        broadcastAlu(DataTag, data);
        base = takeBits(32);
        tag = nextTag();
        pushExpected(tag, addr);
        dispatchOne(makeEntry(loadWord, base, '0, '0, '0, addr - base, tag), '0);

        // uncommitted stores fill every entry
        waitDrained();
        repeat (2) @(posedge clk);
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            base = takeBits(32);
            fullAddr[i] = takeBits(32);
            data = takeBits(32);
            storeTags[i] = nextTag();
            shadow[fullAddr[i][AddrBits-1:0]] = data;
            dispatchOne(makeEntry(storeWord, base, '0, data, '0, fullAddr[i] - base,
                                  storeTags[i]), '0);
        end
        expectFull = 1'b1;
        addr = fullAddr[takeBits(3)];
        base = takeBits(32);
        tag = nextTag();
        pushExpected(tag, addr);
        fork
            dispatchOne(makeEntry(loadWord, base, '0, '0, '0, addr - base, tag), '0);
            begin
                repeat (6) @(posedge clk);
                expectFull = 1'b0;
                for (int i = 0; i < `LSQ_DEPTH; i++) begin
                    commitStore(storeTags[i]);
                end
            end
        join

        waitDrained();
        repeat (10) @(posedge clk);
        $display("%0d load results checked, %0d errors", resultsSeen, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
lsqPkg.sv
issueStage.sv
loadStoreQueue.sv
memoryPort.sv
lsqTop.sv
lsqClock.sv
lsqTb.sv
